/* hdl/noc_defs.svh */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

`define V_NUM    4   // virtual channels per port
`define B_DEPTH  4   // flits per vc
`define P_NUM    5   // router ports
`define FPAY_W   32
`define C_NUM    4   // flit classes
`define WEIGHT_W 4
`define MAX_PCK  1   // atomic reallocation, one packet per vc

// header payload layout, destination first, then class, then weight
`define DST_LSB  0
`define CLS_LSB  (`DST_LSB + `P_NUM - 1)
`define WGT_LSB  (`CLS_LSB + $clog2(`C_NUM))

// candidate vc mask per class, class 0 in the low nibble
`define CLASS_SETTING {4'b1111, 4'b0001, 4'b1100, 4'b0011}

`endif

/* hdl/noc_flit_pkg.sv */
`include "noc_defs.svh"

package noc_flit_pkg;

    // raw payload word, header fields live in its low bits
    typedef logic [`FPAY_W-1:0] payload_t;

    // flit as it travels on the link
    typedef struct packed {
        logic              hdr_flg;   // first flit of a packet
        logic              tail_flg;  // last flit of a packet
        logic [`V_NUM-1:0] vc;        // one-hot vc
        payload_t          payload;
    } flit_t;

    // a single-flit packet carries both flags

endpackage

/* hdl/noc_port_pkg.sv */
`include "noc_defs.svh"

package noc_port_pkg;

    // one bit per virtual channel
    typedef logic [`V_NUM-1:0] vc_mask_t;

    // encoded destination, own port excluded
    typedef logic [`P_NUM-2:0] destport_t;

    typedef logic [$clog2(`C_NUM)-1:0] class_t;

    typedef logic [`WEIGHT_W-1:0] weight_t;

    // per-vc arrays, index is the input vc
    typedef vc_mask_t  [`V_NUM-1:0] vc_mask_arr_t;   // assigned or candidate ovcs
    typedef destport_t [`V_NUM-1:0] destport_arr_t;

endpackage

/* hdl/hdr_info_if.sv */
interface hdr_info_if;
    import noc_port_pkg::*;

    vc_mask_t  flit_wr;      // any flit written, one-hot vc
    vc_mask_t  hdr_wr;       // header written, one-hot vc
    logic      tail_flg;
    class_t    class_in;
    destport_t destport_in;

    modport parser (
        output flit_wr,
        output hdr_wr,
        output tail_flg,
        output class_in,
        output destport_in
    );

    modport store (
        input flit_wr,
        input hdr_wr,
        input tail_flg,
        input class_in,
        input destport_in
    );

endinterface

/* hdl/fwft_fifo.sv */
module fwft_fifo #(
    parameter type data_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  data_t din_i,
    input  logic  wr_en_i,
    input  logic  rd_en_i,
    output data_t dout_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    data_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign pop  = rd_en_i && (count != '0);
    assign push = wr_en_i && ((count != CNT_W'(DEPTH)) || pop);  // full unless popping now

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign dout_o = (count != '0) ? mem[rd_ptr] : '0;  // zero while empty

endmodule

/* hdl/header_parser.sv */
`include "noc_defs.svh"

module header_parser (
    input  logic                  clk,
    input  logic                  reset,
    input  noc_flit_pkg::flit_t   flit_in_i,
    input  logic                  flit_in_we_i,
    hdr_info_if.parser            hdr_o,
    output noc_port_pkg::weight_t iport_weight_o
);
    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    payload_t payload;
    vc_mask_t flit_wr;
    vc_mask_t hdr_wr;
    weight_t  weight_in;

    assign payload = flit_in_i.payload;

    // write strobes follow the one-hot vc field
    assign flit_wr = flit_in_we_i ? flit_in_i.vc : '0;
    assign hdr_wr  = (flit_in_we_i && flit_in_i.hdr_flg) ? flit_in_i.vc : '0;

    assign hdr_o.flit_wr     = flit_wr;
    assign hdr_o.hdr_wr      = hdr_wr;
    assign hdr_o.tail_flg    = flit_in_i.tail_flg;
    assign hdr_o.class_in    = payload[`CLS_LSB +: $bits(class_t)];
    assign hdr_o.destport_in = payload[`DST_LSB +: $bits(destport_t)];

    assign weight_in = payload[`WGT_LSB +: `WEIGHT_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            iport_weight_o <= weight_t'(1);
        end else if (hdr_wr != '0) begin
            // a weight of zero would stall the port, use 1
            iport_weight_o <= (weight_in == '0) ? weight_t'(1) : weight_in;
        end
    end

endmodule

/* hdl/vc_flit_buffer.sv */
`include "noc_defs.svh"

module vc_flit_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  noc_flit_pkg::flit_t    din_i,
    input  noc_port_pkg::vc_mask_t wr_vc_i,
    input  noc_port_pkg::vc_mask_t rd_vc_i,
    input  logic                   rd_en_i,
    output noc_flit_pkg::flit_t    dout_o,
    output noc_port_pkg::vc_mask_t vc_not_empty_o
);
    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    localparam int DEPTH  = `V_NUM * `B_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = $clog2(`B_DEPTH);
    localparam int CNT_W  = $clog2(`B_DEPTH + 1);

    flit_t             mem    [DEPTH];
    logic [PTR_W-1:0]  wr_ptr [`V_NUM];
    logic [PTR_W-1:0]  rd_ptr [`V_NUM];
    logic [CNT_W-1:0]  count  [`V_NUM];
    vc_mask_t          push;
    vc_mask_t          pop;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    always_comb begin
        wr_addr = '0;
        rd_addr = '0;
        for (int v = 0; v < `V_NUM; v++) begin
            pop[v]  = rd_en_i && rd_vc_i[v] && (count[v] != '0);
            push[v] = wr_vc_i[v] && ((count[v] != CNT_W'(`B_DEPTH)) || pop[v]);
            vc_not_empty_o[v] = (count[v] != '0);
            if (wr_vc_i[v]) begin
                wr_addr = ADDR_W'(v * `B_DEPTH) + ADDR_W'(wr_ptr[v]);  // vc region base
            end
            if (rd_vc_i[v]) begin
                rd_addr = ADDR_W'(v * `B_DEPTH) + ADDR_W'(rd_ptr[v]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push != '0) begin
            mem[wr_addr] <= din_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < `V_NUM; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < `V_NUM; v++) begin
                if (push[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + 1'b1;  // wraps inside the region
                end
                if (pop[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + 1'b1;
                end
                case ({push[v], pop[v]})
                    2'b10:   count[v] <= count[v] + 1'b1;
                    2'b01:   count[v] <= count[v] - 1'b1;
                    default: count[v] <= count[v];
                endcase
            end
        end
    end

    assign dout_o = mem[rd_addr];  // head of the granted vc

endmodule

/* hdl/vc_header_info.sv */
`include "noc_defs.svh"

module vc_header_info #(
    parameter int VC_ID = 0
) (
    input  logic                    clk,
    input  logic                    reset,
    hdr_info_if.store               hdr_i,
    input  logic                    rd_grant_i,
    input  logic                    pkt_done_i,
    output logic                    flit_is_tail_o,
    output noc_port_pkg::destport_t dest_port_encoded_o,
    output noc_port_pkg::vc_mask_t  candidate_ovcs_o
);
    import noc_port_pkg::*;

    localparam logic [`C_NUM*`V_NUM-1:0] CLASS_TABLE = `CLASS_SETTING;

    class_t class_head;

    // one tail flag per buffered flit
    fwft_fifo #(
        .data_t (logic),
        .DEPTH  (`B_DEPTH)
    ) tail_fifo (
        .clk     (clk),
        .reset   (reset),
        .din_i   (hdr_i.tail_flg),
        .wr_en_i (hdr_i.flit_wr[VC_ID]),
        .rd_en_i (rd_grant_i),
        .dout_o  (flit_is_tail_o)
    );

    fwft_fifo #(
        .data_t (class_t),
        .DEPTH  (`MAX_PCK)
    ) class_fifo (
        .clk     (clk),
        .reset   (reset),
        .din_i   (hdr_i.class_in),
        .wr_en_i (hdr_i.hdr_wr[VC_ID]),
        .rd_en_i (pkt_done_i),
        .dout_o  (class_head)
    );

    fwft_fifo #(
        .data_t (destport_t),
        .DEPTH  (`MAX_PCK)
    ) dest_fifo (
        .clk     (clk),
        .reset   (reset),
        .din_i   (hdr_i.destport_in),
        .wr_en_i (hdr_i.hdr_wr[VC_ID]),
        .rd_en_i (pkt_done_i),
        .dout_o  (dest_port_encoded_o)
    );

    // class table lookup
    assign candidate_ovcs_o = CLASS_TABLE[class_head * `V_NUM +: `V_NUM];

endmodule

/* hdl/flit_ovc_update.sv */
`include "noc_defs.svh"

module flit_ovc_update (
    input  logic                       clk,
    input  logic                       reset,
    input  noc_flit_pkg::flit_t        flit_i,
    input  noc_port_pkg::vc_mask_t     grant_i,
    input  logic                       granted_i,
    input  noc_port_pkg::vc_mask_arr_t assigned_ovc_num_i,
    output noc_flit_pkg::flit_t        flit_o
);
    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    vc_mask_t ovc_sel;
    flit_t    flit_next;

    // one-hot mux over the assigned ovcs
    always_comb begin
        ovc_sel = '0;
        for (int v = 0; v < `V_NUM; v++) begin
            if (grant_i[v]) begin
                ovc_sel = ovc_sel | assigned_ovc_num_i[v];
            end
        end
        flit_next    = flit_i;
        flit_next.vc = ovc_sel;  // swap input vc for output vc
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_o <= '0;
        end else if (granted_i) begin
            flit_o <= flit_next;
        end
    end

endmodule

/* hdl/input_port.sv */
`include "noc_defs.svh"

module input_port (
    input  logic                        clk,
    input  logic                        reset,
    input  noc_flit_pkg::flit_t         flit_in_i,
    input  logic                        flit_in_we_i,
    input  noc_port_pkg::vc_mask_t      ivc_num_getting_sw_grant_i,
    input  logic                        any_ivc_sw_request_granted_i,
    input  noc_port_pkg::vc_mask_t      reset_ivc_i,
    input  noc_port_pkg::vc_mask_arr_t  assigned_ovc_num_i,
    output noc_flit_pkg::flit_t         flit_out_o,
    output noc_port_pkg::vc_mask_t      flit_is_tail_o,
    output noc_port_pkg::vc_mask_t      ivc_request_o,
    output noc_port_pkg::destport_arr_t dest_port_encoded_o,
    output noc_port_pkg::vc_mask_arr_t  candidate_ovcs_o,
    output noc_port_pkg::weight_t       iport_weight_o
);
    import noc_flit_pkg::*;

    flit_t buffer_out;  // head flit of the granted vc

    hdr_info_if hdr_if ();

    header_parser header_parser_inst (
        .clk            (clk),
        .reset          (reset),
        .flit_in_i      (flit_in_i),
        .flit_in_we_i   (flit_in_we_i),
        .hdr_o          (hdr_if),
        .iport_weight_o (iport_weight_o)
    );

    vc_flit_buffer vc_flit_buffer_inst (
        .clk            (clk),
        .reset          (reset),
        .din_i          (flit_in_i),
        .wr_vc_i        (hdr_if.flit_wr),
        .rd_vc_i        (ivc_num_getting_sw_grant_i),
        .rd_en_i        (any_ivc_sw_request_granted_i),
        .dout_o         (buffer_out),
        .vc_not_empty_o (ivc_request_o)
    );

    for (genvar i = 0; i < `V_NUM; i++) begin : g_vc
        vc_header_info #(
            .VC_ID (i)
        ) vc_header_info_inst (
            .clk                 (clk),
            .reset               (reset),
            .hdr_i               (hdr_if),
            .rd_grant_i          (ivc_num_getting_sw_grant_i[i]),
            .pkt_done_i          (reset_ivc_i[i]),
            .flit_is_tail_o      (flit_is_tail_o[i]),
            .dest_port_encoded_o (dest_port_encoded_o[i]),
            .candidate_ovcs_o    (candidate_ovcs_o[i])
        );
    end

    flit_ovc_update flit_ovc_update_inst (
        .clk                (clk),
        .reset              (reset),
        .flit_i             (buffer_out),
        .grant_i            (ivc_num_getting_sw_grant_i),
        .granted_i          (any_ivc_sw_request_granted_i),
        .assigned_ovc_num_i (assigned_ovc_num_i),
        .flit_o             (flit_out_o)
    );

endmodule

/* bench/input_port_tb.sv */
`include "noc_defs.svh"

module input_port_tb;
    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    localparam int NROWS = 7;

    typedef struct packed {
        int ivc;
        int cls;
        int dst;
        int wgt;
        int len;
        int ovc;    // one-hot output vc from the allocator
        int drain;  // grant pending packets after this one, newest first
    } row_t;

    logic          clk;
    logic          reset;
    flit_t         flit_in_i;
    logic          flit_in_we_i;
    vc_mask_t      ivc_num_getting_sw_grant_i;
    logic          any_ivc_sw_request_granted_i;
    vc_mask_t      reset_ivc_i;
    vc_mask_arr_t  assigned_ovc_num_i;
    flit_t         flit_out_o;
    vc_mask_t      flit_is_tail_o;
    vc_mask_t      ivc_request_o;
    destport_arr_t dest_port_encoded_o;
    vc_mask_arr_t  candidate_ovcs_o;
    weight_t       iport_weight_o;

    row_t        stim [NROWS];
    flit_t       exp_q [`V_NUM][$];  // written flits per vc, oldest first
    int          pending [$];
    vc_mask_t    class_mask [4] = '{4'b0011, 4'b1100, 4'b0001, 4'b1111};

    input_port input_port_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_flit(input string what, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
            stop_run("flit mismatch");
        end
    endtask

    task automatic check_mask(input string what, input vc_mask_t got, input vc_mask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
            stop_run("mask mismatch");
        end
    endtask

    task automatic check_dest(input string what, input destport_t got, input destport_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
            stop_run("destination mismatch");
        end
    endtask

    task automatic check_weight(input string what, input weight_t got, input weight_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
            stop_run("weight mismatch");
        end
    endtask

    task automatic write_packet(input row_t r);
        flit_t    f;
        vc_mask_t oh;
        oh = vc_mask_t'(1 << r.ivc);
        for (int k = 0; k < r.len; k++) begin
            f.hdr_flg  = (k == 0);
            f.tail_flg = (k == r.len - 1);
            f.vc       = oh;
            f.payload  = $urandom;
            if (k == 0) begin  // header fields over the random bits
                f.payload[`DST_LSB +: $bits(destport_t)] = destport_t'(r.dst);
                f.payload[`CLS_LSB +: $bits(class_t)]    = class_t'(r.cls);
                f.payload[`WGT_LSB +: $bits(weight_t)]   = weight_t'(r.wgt);
            end
            exp_q[r.ivc].push_back(f);
            flit_in_i    = f;
            flit_in_we_i = 1'b1;
            @(posedge clk);
            #5;
            flit_in_we_i = 1'b0;
            if (k == 0) begin
                check_mask("request after header", ivc_request_o & oh, oh);
                check_dest("destination", dest_port_encoded_o[r.ivc], destport_t'(r.dst));
                check_mask("candidate ovcs", candidate_ovcs_o[r.ivc], class_mask[r.cls]);
                check_weight("port weight", iport_weight_o,
                             (r.wgt == 0) ? weight_t'(1) : weight_t'(r.wgt));
            end
        end
    endtask

    task automatic drain_packet(input row_t r);
        flit_t    f;
        vc_mask_t oh;
        oh = vc_mask_t'(1 << r.ivc);
        // header info must survive traffic on the other vcs
        check_dest("held destination", dest_port_encoded_o[r.ivc], destport_t'(r.dst));
        check_mask("held candidates", candidate_ovcs_o[r.ivc], class_mask[r.cls]);
        for (int k = 0; k < r.len; k++) begin
            check_mask("tail flag", flit_is_tail_o & oh, (k == r.len - 1) ? oh : '0);
            f    = exp_q[r.ivc].pop_front();
            f.vc = vc_mask_t'(r.ovc);
            ivc_num_getting_sw_grant_i    = oh;
            any_ivc_sw_request_granted_i  = 1'b1;
            for (int v = 0; v < `V_NUM; v++) begin
                assigned_ovc_num_i[v] = ~vc_mask_t'(r.ovc);  // other vcs carry another ovc
            end
            assigned_ovc_num_i[r.ivc]     = vc_mask_t'(r.ovc);
            @(posedge clk);
            #5;
            ivc_num_getting_sw_grant_i   = '0;
            any_ivc_sw_request_granted_i = 1'b0;
            assigned_ovc_num_i           = '0;
            check_flit("granted flit", flit_out_o, f);
        end
        check_mask("request after drain", ivc_request_o & oh, '0);
        check_mask("tail after drain", flit_is_tail_o & oh, '0);
        reset_ivc_i = oh;  // packet done, frees the header stores
        @(posedge clk);
        #5;
        reset_ivc_i = '0;
        check_flit("held output flit", flit_out_o, f);
    endtask

    initial begin
        #((NROWS * 20 + 50) * 40);
        $display("run timed out before all packets were drained");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(58042));
        reset = 1'b1;
        flit_in_i = '0;
        flit_in_we_i = 1'b0;
        ivc_num_getting_sw_grant_i = '0;
        any_ivc_sw_request_granted_i = 1'b0;
        reset_ivc_i = '0;
        assigned_ovc_num_i = '0;
        //          ivc cls dst wgt len ovc drain
        stim[0] = '{0, 0, 3,  5,  3, 2, 1};
        stim[1] = '{1, 1, 9,  0,  1, 4, 0};
        stim[2] = '{2, 2, 12, 7,  4, 1, 0};
        stim[3] = '{3, 3, 6,  15, 2, 8, 1};
        stim[4] = '{0, 3, 15, 2,  4, 8, 0};
        stim[5] = '{2, 1, 1,  0,  2, 4, 1};
        stim[6] = '{1, 2, 0,  9,  1, 1, 1};
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        check_mask("request after reset", ivc_request_o, '0);
        check_mask("tail after reset", flit_is_tail_o, '0);
        check_weight("weight after reset", iport_weight_o, weight_t'(1));
        check_flit("flit_out after reset", flit_out_o, '0);
        for (int r = 0; r < NROWS; r++) begin
            write_packet(stim[r]);
            pending.push_back(r);
            if (stim[r].drain != 0) begin
                while (pending.size() > 0) begin
                    drain_packet(stim[pending.pop_back()]);
                end
            end
        end
        check_mask("final request", ivc_request_o, '0);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/noc_flit_pkg.sv
hdl/noc_port_pkg.sv
hdl/hdr_info_if.sv
hdl/fwft_fifo.sv
hdl/header_parser.sv
hdl/vc_flit_buffer.sv
hdl/vc_header_info.sv
hdl/flit_ovc_update.sv
hdl/input_port.sv
bench/input_port_tb.sv

/* run_sim.sh */
#!/bin/bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary -f sources.f --top-module input_port_tb -o input_port_sim > build.log 2>&1 \
    && ./obj_dir/input_port_sim > sim.log 2>&1 \
    ; grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
